// File: all.f
design/gpu_mem_pkg.sv
design/lsu_arbiter.sv
design/l1_cache.sv
design/mem_arbiter.sv
design/data_memory.sv
design/gpu_mem_top.sv
bench/tb_gpu_mem.sv

// File: Makefile
TOP = tb_gpu_mem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the pass message shows up in the output
run: compile
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: bench/tb_gpu_mem.sv
/*
 * Testbench for the GPU data memory subsystem
 * Directed lane accesses checked against a model of memory and both caches
 */
`timescale 1ns/10ps

module tb_gpu_mem;

    localparam int TIMEOUT_CYCLES = 200;

    logic clk;
    logic reset;
    logic [gpu_mem_pkg::CORES-1:0] cache_flush;
    gpu_mem_pkg::lsu_req_t lsu_req [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES];
    logic [gpu_mem_pkg::CORES-1:0][gpu_mem_pkg::LANES-1:0] lsu_ready;
    gpu_mem_pkg::data_t lsu_rdata [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES];

    // Reference model of the shared memory and each core's lines
    gpu_mem_pkg::data_t mem_m [2**gpu_mem_pkg::ADDR_BITS];
    gpu_mem_pkg::tag_t tag_m [gpu_mem_pkg::CORES][gpu_mem_pkg::LINES];
    gpu_mem_pkg::data_t data_m [gpu_mem_pkg::CORES][gpu_mem_pkg::LINES];
    logic valid_m [gpu_mem_pkg::CORES][gpu_mem_pkg::LINES];
    logic dirty_m [gpu_mem_pkg::CORES][gpu_mem_pkg::LINES];

    int ready_seen [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES];
    int ready_expected [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES];
    int errors;
    int checks;

    gpu_mem_top DUT (
        .clk         (clk),
        .reset       (reset),
        .cache_flush (cache_flush),
        .lsu_req     (lsu_req),
        .lsu_ready   (lsu_ready),
        .lsu_rdata   (lsu_rdata)
    );

    always #10 clk = ~clk;

    // One count per ready pulse since each lasts one cycle
    always @(negedge clk) begin
        for (int c = 0; c < gpu_mem_pkg::CORES; c++) begin
            for (int l = 0; l < gpu_mem_pkg::LANES; l++) begin
                if (!reset && lsu_ready[c][l]) begin
                    ready_seen[c][l]++;
                end
            end
        end
    end

    task automatic check_data(input string name, input gpu_mem_pkg::data_t expected,
                              input gpu_mem_pkg::data_t actual);
        checks++;
        if (expected !== actual) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Write hit stays in the cache while a write miss goes through and allocates clean
    task automatic model_access(input int c, input logic write, input gpu_mem_pkg::addr_t addr,
                                input gpu_mem_pkg::data_t wdata,
                                output gpu_mem_pkg::data_t rdata);
        gpu_mem_pkg::index_t idx;
        gpu_mem_pkg::tag_t tg;
        idx = addr[gpu_mem_pkg::INDEX_BITS-1:0];
        tg = addr[gpu_mem_pkg::ADDR_BITS-1 -: gpu_mem_pkg::TAG_BITS];
        rdata = '0;
        if (valid_m[c][idx] && tag_m[c][idx] == tg) begin
            if (write) begin
                data_m[c][idx] = wdata;
                dirty_m[c][idx] = 1'b1;
            end else begin
                rdata = data_m[c][idx];
            end
        end else begin
            // Dirty victim goes back to memory first
            if (valid_m[c][idx] && dirty_m[c][idx]) begin
                mem_m[{tag_m[c][idx], idx}] = data_m[c][idx];
            end
            if (write) begin
                mem_m[addr] = wdata;
                data_m[c][idx] = wdata;
            end else begin
                data_m[c][idx] = mem_m[addr];
                rdata = data_m[c][idx];
            end
            tag_m[c][idx] = tg;
            valid_m[c][idx] = 1'b1;
            dirty_m[c][idx] = 1'b0;
        end
    endtask

    task automatic lane_access(input int c, input int l, input logic write,
                               input gpu_mem_pkg::addr_t addr, input gpu_mem_pkg::data_t wdata,
                               output gpu_mem_pkg::data_t rdata);
        int cycles;
        logic seen;
        gpu_mem_pkg::data_t expected;
        @(posedge clk);
        #1;
        lsu_req[c][l] = '{read: !write, write: write, addr: addr, wdata: wdata};
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            seen = lsu_ready[c][l];
            cycles++;
        end
        rdata = lsu_rdata[c][l];
        if (seen) begin
            ready_expected[c][l]++;
            model_access(c, write, addr, wdata, expected);
            if (!write) begin
                check_data($sformatf("lsu_rdata[%0d][%0d]", c, l), expected, rdata);
            end
        end else begin
            $display("Timeout at %0t ns: core %0d lane %0d got no lsu_ready for address %h",
                     $time, c, l, addr);
            errors++;
        end
        @(posedge clk);
        #1;
        lsu_req[c][l] = '0;
    endtask

    task automatic flush_core(input int c);
        @(posedge clk);
        #1;
        cache_flush[c] = 1'b1;
        for (int i = 0; i < gpu_mem_pkg::LINES; i++) begin
            valid_m[c][i] = 1'b0;
            dirty_m[c][i] = 1'b0;
        end
        @(posedge clk);
        #1;
        cache_flush[c] = 1'b0;
    endtask

    task automatic compare_ready_counts();
        for (int c = 0; c < gpu_mem_pkg::CORES; c++) begin
            for (int l = 0; l < gpu_mem_pkg::LANES; l++) begin
                check_count($sformatf("lsu_ready[%0d][%0d] pulses", c, l),
                            ready_expected[c][l], ready_seen[c][l]);
            end
        end
    endtask

    task automatic write_read_test();
        gpu_mem_pkg::data_t d;
        gpu_mem_pkg::data_t rd;
        // Write miss followed by a read hit
        d = gpu_mem_pkg::data_t'($urandom);
        lane_access(0, 1, 1'b1, 8'h13, d, rd);
        lane_access(0, 1, 1'b0, 8'h13, '0, rd);
        check_data("lsu_rdata[0][1]", d, rd);
        // Write hit followed by a read hit
        d = gpu_mem_pkg::data_t'($urandom);
        lane_access(0, 1, 1'b1, 8'h13, d, rd);
        lane_access(0, 1, 1'b0, 8'h13, '0, rd);
        check_data("lsu_rdata[0][1]", d, rd);
    endtask

    task automatic eviction_test();
        gpu_mem_pkg::data_t d;
        gpu_mem_pkg::data_t rd;
        d = gpu_mem_pkg::data_t'($urandom);
        lane_access(0, 2, 1'b0, 8'h25, '0, rd);
        lane_access(0, 2, 1'b1, 8'h25, d, rd);
        // Same index with another tag forces a write-back of the dirty line
        lane_access(0, 2, 1'b0, 8'h75, '0, rd);
        lane_access(0, 2, 1'b0, 8'h25, '0, rd);
        check_data("lsu_rdata[0][2]", d, rd);
    endtask

    task automatic all_lanes_test();
        gpu_mem_pkg::data_t rd [gpu_mem_pkg::LANES];
        fork
            lane_access(1, 0, 1'b0, 8'h31, '0, rd[0]);
            lane_access(1, 1, 1'b1, 8'h41, gpu_mem_pkg::data_t'($urandom), rd[1]);
            lane_access(1, 2, 1'b0, 8'h32, '0, rd[2]);
            lane_access(1, 3, 1'b1, 8'h3a, gpu_mem_pkg::data_t'($urandom), rd[3]);
        join
        repeat (4) @(posedge clk);
        compare_ready_counts();
    endtask

    // Different indexes per round keep the two cores off each other's bytes
    task automatic two_core_random_test();
        int idx0;
        int idx1;
        gpu_mem_pkg::addr_t a0;
        gpu_mem_pkg::addr_t a1;
        gpu_mem_pkg::data_t rd0;
        gpu_mem_pkg::data_t rd1;
        for (int round = 0; round < 24; round++) begin
            idx0 = $urandom_range(0, 3);
            idx1 = (idx0 + $urandom_range(1, 3)) % 4;
            a0 = {gpu_mem_pkg::tag_t'($urandom_range(0, 2)), gpu_mem_pkg::index_t'(idx0)};
            a1 = {gpu_mem_pkg::tag_t'($urandom_range(0, 2)), gpu_mem_pkg::index_t'(idx1)};
            fork
                lane_access(0, $urandom_range(0, 3), 1'($urandom_range(0, 1)), a0,
                            gpu_mem_pkg::data_t'($urandom), rd0);
                lane_access(1, $urandom_range(0, 3), 1'($urandom_range(0, 1)), a1,
                            gpu_mem_pkg::data_t'($urandom), rd1);
            join
        end
    endtask

    task automatic flush_test();
        gpu_mem_pkg::data_t rd;
        gpu_mem_pkg::data_t lost;
        lane_access(0, 3, 1'b0, 8'h5e, '0, rd);
        lost = ~mem_m[8'h5e];
        lane_access(0, 3, 1'b1, 8'h5e, lost, rd);
        flush_core(0);
        lane_access(0, 3, 1'b0, 8'h5e, '0, rd);
        check_data("lsu_rdata[0][3]", mem_m[8'h5e], rd);
    endtask

    task automatic write_through_test();
        gpu_mem_pkg::data_t d;
        gpu_mem_pkg::data_t rd;
        d = gpu_mem_pkg::data_t'($urandom);
        lane_access(0, 0, 1'b1, 8'hd9, d, rd);
        lane_access(1, 2, 1'b0, 8'hd9, '0, rd);
        check_data("lsu_rdata[1][2]", d, rd);
    endtask

    initial begin
        void'($urandom(85609));
        clk = 1'b0;
        reset = 1'b1;
        cache_flush = '0;
        errors = 0;
        checks = 0;
        for (int c = 0; c < gpu_mem_pkg::CORES; c++) begin
            for (int l = 0; l < gpu_mem_pkg::LANES; l++) begin
                lsu_req[c][l] = '0;
                ready_seen[c][l] = 0;
                ready_expected[c][l] = 0;
            end
            for (int i = 0; i < gpu_mem_pkg::LINES; i++) begin
                valid_m[c][i] = 1'b0;
                dirty_m[c][i] = 1'b0;
            end
        end
        for (int i = 0; i < 2**gpu_mem_pkg::ADDR_BITS; i++) begin
            mem_m[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        write_read_test();
        eviction_test();
        all_lanes_test();
        two_core_random_test();
        flush_test();
        write_through_test();
        repeat (4) @(posedge clk);
        compare_ready_counts();

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: design/gpu_mem_top.sv
/*
 * GPU data memory subsystem top
 * Two cores' L1 caches sharing one APB data memory through an arbiter
 */
`timescale 1ns/10ps

module gpu_mem_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [gpu_mem_pkg::CORES-1:0] cache_flush,
    input  gpu_mem_pkg::lsu_req_t lsu_req [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES],
    output logic [gpu_mem_pkg::CORES-1:0][gpu_mem_pkg::LANES-1:0] lsu_ready,
    output gpu_mem_pkg::data_t    lsu_rdata [gpu_mem_pkg::CORES][gpu_mem_pkg::LANES]
);

    gpu_mem_pkg::mem_req_t cache_req [gpu_mem_pkg::CORES];
    gpu_mem_pkg::mem_rsp_t cache_rsp [gpu_mem_pkg::CORES];

    // APB between arbiter and RAM
    logic psel;
    logic penable;
    logic pwrite;
    logic pready;
    gpu_mem_pkg::addr_t paddr;
    gpu_mem_pkg::data_t pwdata;
    gpu_mem_pkg::data_t prdata;

    for (genvar c = 0; c < gpu_mem_pkg::CORES; c++) begin : g_core
        l1_cache u_l1_cache (
            .clk         (clk),
            .reset       (reset),
            .cache_flush (cache_flush[c]),
            .lsu_req     (lsu_req[c]),
            .lsu_ready   (lsu_ready[c]),
            .lsu_rdata   (lsu_rdata[c]),
            .mem_req     (cache_req[c]),
            .mem_rsp     (cache_rsp[c])
        );
    end

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// File: design/data_memory.sv
/*
 * 256-byte data RAM on APB with one wait state
 */
`timescale 1ns/10ps

module data_memory (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  gpu_mem_pkg::addr_t paddr,
    input  gpu_mem_pkg::data_t pwdata,
    output gpu_mem_pkg::data_t prdata,
    output logic               pready
);

    gpu_mem_pkg::data_t mem [2**gpu_mem_pkg::ADDR_BITS];
    logic wait_q;

    // First access cycle sets wait_q, second one completes
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= psel && penable && !wait_q;
        end
    end

    assign pready = psel && penable && wait_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**gpu_mem_pkg::ADDR_BITS; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && pwrite) begin
            mem[paddr] <= pwdata;
        end
    end

    assign prdata = mem[paddr];

endmodule

// File: design/mem_arbiter.sv
/*
 * Memory arbiter for the two caches
 * Grants one cache at a time and runs its transfer as APB master
 */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  gpu_mem_pkg::mem_req_t  cache_req [gpu_mem_pkg::CORES],
    output gpu_mem_pkg::mem_rsp_t  cache_rsp [gpu_mem_pkg::CORES],
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output gpu_mem_pkg::addr_t     paddr,
    output gpu_mem_pkg::data_t     pwdata,
    input  gpu_mem_pkg::data_t     prdata,
    input  logic                   pready
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SETUP,
        ARB_ACCESS,
        ARB_DONE
    } arb_state_t;

    arb_state_t state;
    logic grant;
    logic pick;
    gpu_mem_pkg::data_t rdata_q;

    // Grant doubles as the round-robin pointer and the other core goes first
    assign pick = cache_req[~grant].req ? ~grant : grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARB_IDLE;
            grant <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (cache_req[0].req || cache_req[1].req) begin
                        grant <= pick;
                        state <= ARB_SETUP;
                    end
                end
                ARB_SETUP: state <= ARB_ACCESS;
                ARB_ACCESS: begin
                    if (pready) begin
                        state <= ARB_DONE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_ACCESS && pready) begin
            rdata_q <= prdata;
        end
    end

    // Address and data come straight from the granted cache that holds them
    assign psel = (state == ARB_SETUP) || (state == ARB_ACCESS);
    assign penable = (state == ARB_ACCESS);
    assign pwrite = cache_req[grant].write;
    assign paddr = cache_req[grant].addr;
    assign pwdata = cache_req[grant].wdata;

    always_comb begin
        for (int i = 0; i < gpu_mem_pkg::CORES; i++) begin
            cache_rsp[i].done = (state == ARB_DONE) && (grant == 1'(i));
            cache_rsp[i].rdata = rdata_q;
        end
    end

    a_grant_requests: assert property (@(posedge clk) disable iff (reset)
        psel |-> cache_req[grant].req);
    a_paddr_stable: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=> $stable(paddr));

endmodule

// File: design/l1_cache.sv
/*
 * Per-core direct-mapped L1 data cache with write-back of dirty lines
 * Write misses go through to memory and allocate a clean line
 */
`timescale 1ns/10ps

module l1_cache (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cache_flush,
    input  gpu_mem_pkg::lsu_req_t  lsu_req [gpu_mem_pkg::LANES],
    output logic [gpu_mem_pkg::LANES-1:0] lsu_ready,
    output gpu_mem_pkg::data_t     lsu_rdata [gpu_mem_pkg::LANES],
    output gpu_mem_pkg::mem_req_t  mem_req,
    input  gpu_mem_pkg::mem_rsp_t  mem_rsp
);

    gpu_mem_pkg::cache_state_t state, next_state;

    // Line arrays
    gpu_mem_pkg::data_t data_q [gpu_mem_pkg::LINES];
    gpu_mem_pkg::tag_t tag_q [gpu_mem_pkg::LINES];
    logic [gpu_mem_pkg::LINES-1:0] valid_q;
    logic [gpu_mem_pkg::LINES-1:0] dirty_q;

    gpu_mem_pkg::lane_id_t lane;
    logic pending;
    gpu_mem_pkg::lsu_req_t cur_req;

    gpu_mem_pkg::index_t index;
    gpu_mem_pkg::tag_t tag;
    logic hit;

    lsu_arbiter u_lsu_arbiter (
        .clk     (clk),
        .reset   (reset),
        .lsu_req (lsu_req),
        .idle    (state == gpu_mem_pkg::IDLE),
        .lane    (lane),
        .pending (pending)
    );

    assign index = cur_req.addr[gpu_mem_pkg::INDEX_BITS-1:0];
    assign tag = cur_req.addr[gpu_mem_pkg::ADDR_BITS-1 -: gpu_mem_pkg::TAG_BITS];
    assign hit = valid_q[index] && (tag_q[index] == tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= gpu_mem_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            gpu_mem_pkg::IDLE: begin
                if (pending) begin
                    next_state = gpu_mem_pkg::CHECK_HIT;
                end
            end
            gpu_mem_pkg::CHECK_HIT: begin
                if (hit) begin
                    next_state = gpu_mem_pkg::COMPLETE;
                end else if (valid_q[index] && dirty_q[index]) begin
                    next_state = gpu_mem_pkg::WRITEBACK;
                end else if (cur_req.read) begin
                    next_state = gpu_mem_pkg::ALLOCATE_READ;
                end else begin
                    next_state = gpu_mem_pkg::ALLOCATE_WRITE;
                end
            end
            gpu_mem_pkg::WRITEBACK: begin
                if (mem_rsp.done) begin
                    next_state = cur_req.read ? gpu_mem_pkg::ALLOCATE_READ
                                              : gpu_mem_pkg::ALLOCATE_WRITE;
                end
            end
            gpu_mem_pkg::ALLOCATE_READ, gpu_mem_pkg::ALLOCATE_WRITE: begin
                if (mem_rsp.done) begin
                    next_state = gpu_mem_pkg::COMPLETE;
                end
            end
            default: begin
                next_state = gpu_mem_pkg::IDLE;
            end
        endcase
    end

    // Request latched once as the FSM leaves IDLE
    always_ff @(posedge clk) begin
        if (state == gpu_mem_pkg::IDLE && pending) begin
            cur_req <= lsu_req[lane];
        end
    end

    // Data and tag updates from a write hit or a fill
    always_ff @(posedge clk) begin
        if (state == gpu_mem_pkg::CHECK_HIT && hit && cur_req.write) begin
            data_q[index] <= cur_req.wdata;
        end else if (state == gpu_mem_pkg::ALLOCATE_READ && mem_rsp.done) begin
            data_q[index] <= mem_rsp.rdata;
            tag_q[index] <= tag;
        end else if (state == gpu_mem_pkg::ALLOCATE_WRITE && mem_rsp.done) begin
            data_q[index] <= cur_req.wdata;
            tag_q[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (cache_flush) begin
            // Dirty lines are dropped, not written back
            valid_q <= '0;
            dirty_q <= '0;
        end else if (state == gpu_mem_pkg::CHECK_HIT && hit && cur_req.write) begin
            dirty_q[index] <= 1'b1;
        end else if ((state == gpu_mem_pkg::ALLOCATE_READ ||
                      state == gpu_mem_pkg::ALLOCATE_WRITE) && mem_rsp.done) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end
    end

    // Read data stays put after the ready pulse
    always_ff @(posedge clk) begin
        if (state == gpu_mem_pkg::CHECK_HIT && hit && cur_req.read) begin
            lsu_rdata[lane] <= data_q[index];
        end else if (state == gpu_mem_pkg::ALLOCATE_READ && mem_rsp.done) begin
            lsu_rdata[lane] <= mem_rsp.rdata;
        end
    end

    always_comb begin
        lsu_ready = '0;
        if (state == gpu_mem_pkg::COMPLETE) begin
            lsu_ready[lane] = 1'b1;
        end
    end

    // Victim address rebuilt from the stored tag
    always_comb begin
        mem_req.req = (state == gpu_mem_pkg::WRITEBACK) ||
                      (state == gpu_mem_pkg::ALLOCATE_READ) ||
                      (state == gpu_mem_pkg::ALLOCATE_WRITE);
        mem_req.write = (state != gpu_mem_pkg::ALLOCATE_READ);
        if (state == gpu_mem_pkg::WRITEBACK) begin
            mem_req.addr = {tag_q[index], index};
            mem_req.wdata = data_q[index];
        end else begin
            mem_req.addr = cur_req.addr;
            mem_req.wdata = cur_req.wdata;
        end
    end

    a_ready_served_lane: assert property (@(posedge clk) disable iff (reset)
        (lsu_ready != '0) |-> (lsu_req[lane] == cur_req));
    a_req_held_until_done: assert property (@(posedge clk) disable iff (reset)
        (mem_req.req && !mem_rsp.done) |=> $stable(mem_req));
    a_done_with_req: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.done |-> mem_req.req);

endmodule

// File: design/lsu_arbiter.sv
/*
 * Lane arbiter for one core
 * Round-robin pick among requesting lanes, frozen while the cache is busy
 */
`timescale 1ns/10ps

module lsu_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  gpu_mem_pkg::lsu_req_t  lsu_req [gpu_mem_pkg::LANES],
    input  logic                   idle,
    output gpu_mem_pkg::lane_id_t  lane,
    output logic                   pending
);

    gpu_mem_pkg::lane_id_t held_lane;
    gpu_mem_pkg::lane_id_t next_lane;
    logic [gpu_mem_pkg::LANES-1:0] active;

    always_comb begin
        for (int i = 0; i < gpu_mem_pkg::LANES; i++) begin
            active[i] = lsu_req[i].read | lsu_req[i].write;
        end
    end

    // Farthest candidate first, so the nearest one after held_lane wins
    always_comb begin
        gpu_mem_pkg::lane_id_t cand;
        next_lane = held_lane;
        for (int i = gpu_mem_pkg::LANES - 1; i >= 1; i--) begin
            cand = held_lane + gpu_mem_pkg::lane_id_t'(i);
            if (active[cand]) begin
                next_lane = cand;
            end
        end
        // Current lane keeps the cache while it still asks
        if (active[held_lane]) begin
            next_lane = held_lane;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_lane <= '0;
        end else if (idle) begin
            held_lane <= next_lane;
        end
    end

    // Live pick in IDLE, frozen choice otherwise
    assign lane = idle ? next_lane : held_lane;
    assign pending = active[lane];

endmodule

// File: design/gpu_mem_pkg.sv
/*
 * GPU memory subsystem shared definitions
 * Widths, counts, lane and memory request types and the cache FSM states
 */
package gpu_mem_pkg;

    // Address and data widths
    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 8;

    // Direct-mapped cache geometry, one byte per line
    localparam int LINES = 16;
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS = 4;

    // Load/store lanes per core and core count
    localparam int LANES = 4;
    localparam int LANE_BITS = $clog2(LANES);
    localparam int CORES = 2;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [LANE_BITS-1:0] lane_id_t;

    // One lane's access, held until its ready bit
    typedef struct packed {
        logic read;
        logic write;
        addr_t addr;
        data_t wdata;
    } lsu_req_t;

    // Cache to memory arbiter
    typedef struct packed {
        logic req;
        logic write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // Memory arbiter back to cache, done is a single-cycle pulse
    typedef struct packed {
        logic done;
        data_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECK_HIT,
        WRITEBACK,
        ALLOCATE_READ,
        ALLOCATE_WRITE,
        COMPLETE
    } cache_state_t;

endpackage
